/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_mini_mcu \
	  -f project.f -Mdir obj_dir -o sim_mini_mcu
	./obj_dir/sim_mini_mcu 2>&1 | tee sim.log
	@grep -qx "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* hw/ao_peripheral.sv */
// always-on registers: exit value, machine timer and power manager
// only the low 8 offset bits are decoded, so the 4 KiB region aliases
`timescale 1ns/1ps
`default_nettype none

`include "mini_mcu_cfg.svh"

module ao_peripheral (
  input  wire logic                    clk_i,
  input  wire logic                    rst_i,
  input  wire logic                    req_i,
  input  wire logic                    we_i,
  input  wire logic [7:0]              addr_i,
  input  wire logic [`MCU_DATA_W-1:0]  wdata_i,
  output logic                         rsp_valid_o,
  output logic [`MCU_DATA_W-1:0]       rdata_o,
  output logic                         exit_valid_o,
  output logic [`MCU_DATA_W-1:0]       exit_value_o,
  output logic                         irq_timer_o,
  output logic                         cpu_powergate_o
);

  import mini_mcu_pkg::*;

  localparam int DW = `MCU_DATA_W;

  logic          wr;
  logic          rd;
  logic [DW-1:0] timer_cmp_q;
  logic          timer_en_q;
  logic          timer_clear;
  logic [DW-1:0] timer_value;
  logic          sleep_req;
  pwr_state_e    pwr_state;
  logic [DW-1:0] rdata_d;

  assign wr = req_i && we_i;
  assign rd = req_i && !we_i;

  // single-cycle strobes, since a request lasts one cycle
  assign timer_clear = wr && (addr_i == AO_TIMER_CTRL) && wdata_i[1];
  assign sleep_req   = wr && (addr_i == AO_SLEEP_REQ);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      timer_en_q   <= 1'b0;
      exit_valid_o <= 1'b0;
    end else if (wr) begin
      if (addr_i == AO_TIMER_CTRL) begin
        timer_en_q <= wdata_i[0];
      end
      if (addr_i == AO_EXIT_VALUE) begin
        exit_valid_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr && (addr_i == AO_TIMER_CMP)) begin
      timer_cmp_q <= wdata_i;
    end
    if (wr && (addr_i == AO_EXIT_VALUE)) begin
      exit_value_o <= wdata_i;
    end
  end

  always_comb begin
    case (addr_i)
      AO_EXIT_VALUE: rdata_d = exit_value_o;
      AO_TIMER_CMP:  rdata_d = timer_cmp_q;
      AO_TIMER_CTRL: rdata_d = DW'(timer_en_q);
      AO_TIMER_VAL:  rdata_d = timer_value;
      AO_PWR_STATE:  rdata_d = DW'(pwr_state);
      default:       rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= req_i;
    end
  end

  // write responses carry zero
  always_ff @(posedge clk_i) begin
    rdata_o <= rd ? rdata_d : '0;
  end

  machine_timer u_machine_timer (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .enable_i  (timer_en_q),
    .clear_i   (timer_clear),
    .compare_i (timer_cmp_q),
    .value_o   (timer_value),
    .irq_o     (irq_timer_o)
  );

  power_manager u_power_manager (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .sleep_req_i (sleep_req),
    .wake_irq_i  (irq_timer_o),
    .state_o     (pwr_state),
    .powergate_o (cpu_powergate_o)
  );

endmodule

`default_nettype wire

/* hw/machine_timer.sv */
// free-running counter, wraps at 2**32
// clear wins over enable; the interrupt is a level, not a pulse
`timescale 1ns/1ps
`default_nettype none

`include "mini_mcu_cfg.svh"

module machine_timer (
  input  wire logic                    clk_i,
  input  wire logic                    rst_i,
  input  wire logic                    enable_i,
  input  wire logic                    clear_i,
  input  wire logic [`MCU_DATA_W-1:0]  compare_i,
  output logic [`MCU_DATA_W-1:0]       value_o,
  output logic                         irq_o
);

  localparam int DW = `MCU_DATA_W;

  logic [DW-1:0] value_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      value_q <= '0;
    end else if (clear_i) begin
      value_q <= '0;
    end else if (enable_i) begin
      value_q <= value_q + 1'b1;
    end
  end

  assign value_o = value_q;

  // held while enabled and at or past compare
  assign irq_o = enable_i && (value_q >= compare_i);

endmodule

`default_nettype wire

/* hw/memory_bank.sv */
// single-port word RAM, one request per cycle
// contents power up undefined; writes answer with zero read data
`timescale 1ns/1ps
`default_nettype none

`include "mini_mcu_cfg.svh"

module memory_bank (
  input  wire logic                               clk_i,
  input  wire logic                               req_i,
  input  wire logic                               we_i,
  input  wire logic [$clog2(`MCU_RAM_WORDS)-1:0]  addr_i,
  input  wire logic [`MCU_DATA_W-1:0]             wdata_i,
  output logic                                    rsp_valid_o,
  output logic [`MCU_DATA_W-1:0]                  rdata_o
);

  localparam int DW    = `MCU_DATA_W;
  localparam int WORDS = `MCU_RAM_WORDS;

  logic [DW-1:0] mem_q [WORDS];

  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      mem_q[addr_i] <= wdata_i;
    end
  end

  // response one cycle after the request
  always_ff @(posedge clk_i) begin
    rsp_valid_o <= req_i;
    if (req_i) begin
      if (we_i) begin
        rdata_o <= '0;
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

`default_nettype wire

/* hw/mini_mcu.sv */
// subsystem top: bus, word RAM and always-on block, no CPU
// full 32-bit word accesses only, no byte enables
`timescale 1ns/1ps
`default_nettype none

`include "mini_mcu_cfg.svh"

module mini_mcu (
  input  wire logic                    clk_i,
  input  wire logic                    rst_i,
  input  wire logic                    req_valid_i,
  input  wire mini_mcu_pkg::bus_op_e   req_op_i,
  input  wire logic [`MCU_DATA_W-1:0]  req_addr_i,
  input  wire logic [`MCU_DATA_W-1:0]  req_wdata_i,
  output logic                         credit_o,
  output logic                         rsp_valid_o,
  output logic                         rsp_err_o,
  output logic [`MCU_DATA_W-1:0]       rsp_rdata_o,
  output logic                         exit_valid_o,
  output logic [`MCU_DATA_W-1:0]       exit_value_o,
  output logic                         irq_timer_o,
  output logic                         cpu_powergate_o
);

  localparam int DW     = `MCU_DATA_W;
  localparam int RAM_AW = $clog2(`MCU_RAM_WORDS);

  // ram port
  logic              ram_req;
  logic              ram_we;
  logic [RAM_AW-1:0] ram_addr;
  logic [DW-1:0]     ram_wdata;
  logic              ram_rsp_valid;
  logic [DW-1:0]     ram_rdata;

  // always-on port
  logic              ao_req;
  logic              ao_we;
  logic [7:0]        ao_addr;
  logic [DW-1:0]     ao_wdata;
  logic              ao_rsp_valid;
  logic [DW-1:0]     ao_rdata;

  system_bus u_system_bus (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .req_valid_i     (req_valid_i),
    .req_op_i        (req_op_i),
    .req_addr_i      (req_addr_i),
    .req_wdata_i     (req_wdata_i),
    .credit_o        (credit_o),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_err_o       (rsp_err_o),
    .rsp_rdata_o     (rsp_rdata_o),
    .ram_req_o       (ram_req),
    .ram_we_o        (ram_we),
    .ram_addr_o      (ram_addr),
    .ram_wdata_o     (ram_wdata),
    .ram_rsp_valid_i (ram_rsp_valid),
    .ram_rdata_i     (ram_rdata),
    .ao_req_o        (ao_req),
    .ao_we_o         (ao_we),
    .ao_addr_o       (ao_addr),
    .ao_wdata_o      (ao_wdata),
    .ao_rsp_valid_i  (ao_rsp_valid),
    .ao_rdata_i      (ao_rdata)
  );

  memory_bank u_memory_bank (
    .clk_i       (clk_i),
    .req_i       (ram_req),
    .we_i        (ram_we),
    .addr_i      (ram_addr),
    .wdata_i     (ram_wdata),
    .rsp_valid_o (ram_rsp_valid),
    .rdata_o     (ram_rdata)
  );

  ao_peripheral u_ao_peripheral (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .req_i           (ao_req),
    .we_i            (ao_we),
    .addr_i          (ao_addr),
    .wdata_i         (ao_wdata),
    .rsp_valid_o     (ao_rsp_valid),
    .rdata_o         (ao_rdata),
    .exit_valid_o    (exit_valid_o),
    .exit_value_o    (exit_value_o),
    .irq_timer_o     (irq_timer_o),
    .cpu_powergate_o (cpu_powergate_o)
  );

endmodule

`default_nettype wire

/* hw/mini_mcu_cfg.svh */
// build-time sizes and address map of the subsystem
// RAM depth must be a power of two, so addresses wrap inside the region
`ifndef MINI_MCU_CFG_SVH
`define MINI_MCU_CFG_SVH

// data and address width
`define MCU_DATA_W 32

// RAM depth in 32-bit words
`define MCU_RAM_WORDS 256

// request buffer depth, equal to the credits granted after reset
`define MCU_CREDITS 2

// each region spans 2**MCU_REGION_W bytes
`define MCU_REGION_W 12

// region bases
`define MCU_RAM_BASE 32'h0000_0000
`define MCU_AO_BASE 32'h2000_0000

`endif

/* hw/mini_mcu_pkg.sv */
// bus, region and power types shared by the subsystem
// AO offsets are byte offsets; only the low 8 address bits are decoded
`default_nettype none

package mini_mcu_pkg;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } bus_op_e;

  typedef enum logic [1:0] {
    REG_RAM  = 2'd0,
    REG_AO   = 2'd1,
    REG_NONE = 2'd2
  } region_e;

  typedef enum logic [1:0] {
    PWR_ACTIVE = 2'd0,
    PWR_SLEEP  = 2'd1,
    PWR_WAKE   = 2'd2
  } pwr_state_e;

  // always-on register offsets
  localparam logic [7:0] AO_EXIT_VALUE = 8'h00;
  localparam logic [7:0] AO_TIMER_CMP  = 8'h04;
  localparam logic [7:0] AO_TIMER_CTRL = 8'h08;
  localparam logic [7:0] AO_TIMER_VAL  = 8'h0C;
  localparam logic [7:0] AO_SLEEP_REQ  = 8'h10;
  localparam logic [7:0] AO_PWR_STATE  = 8'h14;

endpackage

`default_nettype wire

/* hw/power_manager.sv */
// cpu power gating FSM: sleep on request, wake on timer interrupt
// a sleep request outside PWR_ACTIVE is dropped
`timescale 1ns/1ps
`default_nettype none

module power_manager (
  input  wire logic               clk_i,
  input  wire logic               rst_i,
  input  wire logic               sleep_req_i,
  input  wire logic               wake_irq_i,
  output mini_mcu_pkg::pwr_state_e state_o,
  output logic                    powergate_o
);

  import mini_mcu_pkg::*;

  pwr_state_e state_q;
  pwr_state_e state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      PWR_ACTIVE: begin
        if (sleep_req_i) begin
          state_d = PWR_SLEEP;
        end
      end
      PWR_SLEEP: begin
        if (wake_irq_i) begin
          state_d = PWR_WAKE;
        end
      end
      // one cycle to restore power
      PWR_WAKE: state_d = PWR_ACTIVE;
      default:  state_d = PWR_ACTIVE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= PWR_ACTIVE;
    end else begin
      state_q <= state_d;
    end
  end

  // gate set on accepted sleep, released on wake
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      powergate_o <= 1'b0;
    end else if ((state_q == PWR_ACTIVE) && sleep_req_i) begin
      powergate_o <= 1'b1;
    end else if ((state_q == PWR_SLEEP) && wake_irq_i) begin
      powergate_o <= 1'b0;
    end
  end

  assign state_o = state_q;

  a_gate_matches_state: assert property (
    @(posedge clk_i) disable iff (rst_i) powergate_o == (state_q == PWR_SLEEP)
  );

endmodule

`default_nettype wire

/* hw/system_bus.sv */
// credit-based request buffer with one dispatch per cycle
// the master must hold a credit before each request; responses have no back-pressure
`timescale 1ns/1ps
`default_nettype none

`include "mini_mcu_cfg.svh"

module system_bus (
  input  wire logic                                   clk_i,
  input  wire logic                                   rst_i,
  input  wire logic                                   req_valid_i,
  input  wire mini_mcu_pkg::bus_op_e                  req_op_i,
  input  wire logic [`MCU_DATA_W-1:0]                 req_addr_i,
  input  wire logic [`MCU_DATA_W-1:0]                 req_wdata_i,
  output logic                                        credit_o,
  output logic                                        rsp_valid_o,
  output logic                                        rsp_err_o,
  output logic [`MCU_DATA_W-1:0]                      rsp_rdata_o,
  output logic                                        ram_req_o,
  output logic                                        ram_we_o,
  output logic [$clog2(`MCU_RAM_WORDS)-1:0]           ram_addr_o,
  output logic [`MCU_DATA_W-1:0]                      ram_wdata_o,
  input  wire logic                                   ram_rsp_valid_i,
  input  wire logic [`MCU_DATA_W-1:0]                 ram_rdata_i,
  output logic                                        ao_req_o,
  output logic                                        ao_we_o,
  output logic [7:0]                                  ao_addr_o,
  output logic [`MCU_DATA_W-1:0]                      ao_wdata_o,
  input  wire logic                                   ao_rsp_valid_i,
  input  wire logic [`MCU_DATA_W-1:0]                 ao_rdata_i
);

  import mini_mcu_pkg::*;

  localparam int DW     = `MCU_DATA_W;
  localparam int DEPTH  = `MCU_CREDITS;
  localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W  = $clog2(DEPTH + 1);
  localparam int RAM_AW = $clog2(`MCU_RAM_WORDS);
  localparam int RGN_W  = `MCU_REGION_W;
  localparam logic [DW-1:0] RAM_BASE = `MCU_RAM_BASE;
  localparam logic [DW-1:0] AO_BASE  = `MCU_AO_BASE;

  bus_op_e           op_q    [DEPTH];
  logic [DW-1:0]     addr_q  [DEPTH];
  logic [DW-1:0]     wdata_q [DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_W-1:0]  count_q;
  logic              full;
  logic              pop;
  bus_op_e           head_op;
  logic [DW-1:0]     head_addr;
  region_e           head_region;
  logic              err_valid_q;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full = (count_q == CNT_W'(DEPTH));
  // head leaves the buffer in every non-empty cycle
  assign pop  = (count_q != '0);
  assign credit_o = pop;

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      op_q[wr_ptr_q]    <= req_op_i;
      addr_q[wr_ptr_q]  <= req_addr_i;
      wdata_q[wr_ptr_q] <= req_wdata_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (req_valid_i) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      count_q <= count_q + CNT_W'(req_valid_i) - CNT_W'(pop);
    end
  end

  assign head_op   = op_q[rd_ptr_q];
  assign head_addr = addr_q[rd_ptr_q];

  // address decode on the 4 KiB region number
  always_comb begin
    if (head_addr[DW-1:RGN_W] == RAM_BASE[DW-1:RGN_W]) begin
      head_region = REG_RAM;
    end else if (head_addr[DW-1:RGN_W] == AO_BASE[DW-1:RGN_W]) begin
      head_region = REG_AO;
    end else begin
      head_region = REG_NONE;
    end
  end

  assign ram_req_o   = pop && (head_region == REG_RAM);
  assign ram_we_o    = (head_op == OP_WRITE);
  assign ram_addr_o  = head_addr[2 +: RAM_AW];
  assign ram_wdata_o = wdata_q[rd_ptr_q];
  assign ao_req_o    = pop && (head_region == REG_AO);
  assign ao_we_o     = (head_op == OP_WRITE);
  assign ao_addr_o   = head_addr[7:0];
  assign ao_wdata_o  = wdata_q[rd_ptr_q];

  // unmapped accesses answer with the same one-cycle latency as a target
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      err_valid_q <= 1'b0;
    end else begin
      err_valid_q <= pop && (head_region == REG_NONE);
    end
  end

  assign rsp_valid_o = ram_rsp_valid_i | ao_rsp_valid_i | err_valid_q;
  assign rsp_err_o   = err_valid_q;
  assign rsp_rdata_o = ram_rsp_valid_i ? ram_rdata_i :
                       ao_rsp_valid_i  ? ao_rdata_i  : '0;

  a_no_push_when_full: assert property (
    @(posedge clk_i) disable iff (rst_i) req_valid_i |-> !full
  );

  a_one_response: assert property (
    @(posedge clk_i) disable iff (rst_i)
      $onehot0({ram_rsp_valid_i, ao_rsp_valid_i, err_valid_q})
  );

endmodule

`default_nettype wire

/* project.f */
+incdir+hw
hw/mini_mcu_pkg.sv
hw/machine_timer.sv
hw/power_manager.sv
hw/memory_bank.sv
hw/ao_peripheral.sv
hw/system_bus.sv
hw/mini_mcu.sv
verif/tb_mini_mcu.sv

/* verif/bus_patterns.txt */
# name op addr wdata exp_rdata exp_err, all values in hex
# op is wr or rd; writes expect zero read data; exp_err 1 marks an unmapped access
ram_wr_lo     wr 00000000 11223344 00000000 0
ram_wr_mid    wr 00000120 deadbeef 00000000 0
ram_wr_top    wr 000003fc a5a55a5a 00000000 0
ram_rd_lo     rd 00000000 00000000 11223344 0
ram_rd_mid    rd 00000120 00000000 deadbeef 0
ram_rd_wrap   rd 00000ffc 00000000 a5a55a5a 0
ram_wr_alias  wr 00000404 0badf00d 00000000 0
ram_rd_alias  rd 00000004 00000000 0badf00d 0
ao_rd_pwr     rd 20000014 00000000 00000000 0
ao_wr_cmp     wr 20000004 00000055 00000000 0
ao_rd_cmp     rd 20000004 00000000 00000055 0
ao_wr_unknown wr 20000024 ffffffff 00000000 0
ao_rd_unknown rd 20000024 00000000 00000000 0
unmap_rd      rd 10000000 00000000 00000000 1
unmap_wr      wr 00001000 12345678 00000000 1
unmap_rd_hi   rd fffffffc 00000000 00000000 1

/* verif/tb_mini_mcu.sv */
// bus-level testbench for mini_mcu, run from the project root
// RAM, AO and unmapped patterns come from verif/bus_patterns.txt
`timescale 1ns/1ps
`default_nettype none

`include "mini_mcu_cfg.svh"

module tb_mini_mcu;

  import mini_mcu_pkg::*;

  localparam int DW      = `MCU_DATA_W;
  localparam int CREDITS = `MCU_CREDITS;
  localparam int TIMEOUT = 500;
  localparam logic [DW-1:0] AO_BASE   = `MCU_AO_BASE;
  localparam logic [DW-1:0] TIMER_CMP = 32'd20;
  localparam logic [DW-1:0] EXIT_CODE = 32'hc0de_0042;

  logic          clk_i;
  logic          rst_i;
  logic          req_valid_i;
  bus_op_e       req_op_i;
  logic [DW-1:0] req_addr_i;
  logic [DW-1:0] req_wdata_i;
  logic          credit_o;
  logic          rsp_valid_o;
  logic          rsp_err_o;
  logic [DW-1:0] rsp_rdata_o;
  logic          exit_valid_o;
  logic [DW-1:0] exit_value_o;
  logic          irq_timer_o;
  logic          cpu_powergate_o;

  int            credits;
  int            value_errors;
  int            other_errors;
  logic [DW-1:0] last_rdata;
  logic [DW-1:0] exp_data_q [$];
  logic          exp_err_q [$];
  logic          exp_chk_q [$];
  string         exp_name_q [$];

  mini_mcu u_mini_mcu (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .req_valid_i     (req_valid_i),
    .req_op_i        (req_op_i),
    .req_addr_i      (req_addr_i),
    .req_wdata_i     (req_wdata_i),
    .credit_o        (credit_o),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_err_o       (rsp_err_o),
    .rsp_rdata_o     (rsp_rdata_o),
    .exit_valid_o    (exit_valid_o),
    .exit_value_o    (exit_value_o),
    .irq_timer_o     (irq_timer_o),
    .cpu_powergate_o (cpu_powergate_o)
  );

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  task automatic check_value(input string name, input logic [DW-1:0] expected,
                             input logic [DW-1:0] actual);
    if (actual !== expected) begin
      value_errors++;
      $display("** Error: %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic end_run();
    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    other_errors++;
    $display("timeout while waiting for %s", what);
    end_run();
  endtask

  // every driver step lands 1 ns after the rising edge
  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  task automatic check_response();
    string         name;
    logic [DW-1:0] exp_data;
    logic          exp_err;
    logic          chk;
    if (exp_data_q.size() == 0) begin
      other_errors++;
      $display("response arrived with no request outstanding");
    end else begin
      name     = exp_name_q.pop_front();
      exp_data = exp_data_q.pop_front();
      exp_err  = exp_err_q.pop_front();
      chk      = exp_chk_q.pop_front();
      last_rdata = rsp_rdata_o;
      check_value({name, "_err"}, DW'(exp_err), DW'(rsp_err_o));
      if (chk) begin
        check_value(name, exp_data, rsp_rdata_o);
      end
    end
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk_i) begin
    if (!rst_i) begin
      if (credit_o) begin
        credits = credits + 1;
        if (credits > CREDITS) begin
          other_errors++;
          $display("more credits returned than were granted at reset");
        end
      end
      if (rsp_valid_o) begin
        check_response();
      end
    end
  end

  task automatic send_req(input string name, input bus_op_e op,
                          input logic [DW-1:0] addr, input logic [DW-1:0] wdata,
                          input logic [DW-1:0] exp_rdata, input logic exp_err,
                          input logic chk);
    int waited;
    waited = 0;
    while (credits == 0 && waited < TIMEOUT) begin
      step();
      waited++;
    end
    if (credits == 0) begin
      report_timeout("a returned credit");
    end else begin
      exp_name_q.push_back(name);
      exp_data_q.push_back(exp_rdata);
      exp_err_q.push_back(exp_err);
      exp_chk_q.push_back(chk);
      req_valid_i = 1'b1;
      req_op_i    = op;
      req_addr_i  = addr;
      req_wdata_i = wdata;
      credits     = credits - 1;
      step();
      req_valid_i = 1'b0;
    end
  endtask

  task automatic write_word(input string name, input logic [DW-1:0] addr,
                            input logic [DW-1:0] data);
    send_req(name, OP_WRITE, addr, data, '0, 1'b0, 1'b1);
  endtask

  task automatic read_word(input string name, input logic [DW-1:0] addr,
                           input logic [DW-1:0] exp_rdata, input logic chk);
    send_req(name, OP_READ, addr, '0, exp_rdata, 1'b0, chk);
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    while ((exp_data_q.size() != 0 || credits != CREDITS) && waited < TIMEOUT) begin
      step();
      waited++;
    end
    if (waited >= TIMEOUT) begin
      report_timeout("outstanding responses and credits");
    end
  endtask

  function automatic logic watched(input string what);
    if (what == "irq_timer_o") begin
      return irq_timer_o;
    end
    return cpu_powergate_o;
  endfunction

  task automatic wait_for(input string what, input logic level);
    int waited;
    waited = 0;
    while (watched(what) !== level && waited < TIMEOUT) begin
      step();
      waited++;
    end
    if (waited >= TIMEOUT) begin
      report_timeout(what);
    end
  endtask

  function automatic logic [DW-1:0] fill_word(input logic [DW-1:0] addr);
    return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5a3c_96e1;
  endfunction

  task automatic play_patterns();
    int            fd;
    int            n;
    int            played;
    int            gap;
    int            err_bit;
    string         line;
    string         name;
    string         op_s;
    logic [DW-1:0] addr;
    logic [DW-1:0] wdata;
    logic [DW-1:0] rdata;
    played = 0;
    fd = $fopen("verif/bus_patterns.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("cannot open verif/bus_patterns.txt");
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%s %s %h %h %h %d", name, op_s, addr, wdata, rdata, err_bit);
          if (n != 6 || (op_s != "rd" && op_s != "wr")) begin
            other_errors++;
            $display("malformed pattern line: %s", line);
          end else begin
            gap = int'($urandom_range(3, 0));
            repeat (gap) step();
            send_req(name, (op_s == "wr") ? OP_WRITE : OP_READ, addr, wdata, rdata,
                     err_bit[0], 1'b1);
            played++;
          end
        end
      end
      $fclose(fd);
      wait_idle();
      if (played == 0) begin
        other_errors++;
        $display("no bus patterns were played");
      end
    end
  endtask

  // requests go out as fast as credits come back
  task automatic run_burst();
    logic [DW-1:0] addr;
    for (int i = 0; i < 8; i++) begin
      addr = 32'h0000_0200 + DW'(i * 4);
      write_word("burst_wr", addr, fill_word(addr));
    end
    for (int i = 0; i < 8; i++) begin
      addr = 32'h0000_0200 + DW'(i * 4);
      read_word("burst_rd", addr, fill_word(addr), 1'b1);
    end
    wait_idle();
    repeat (4) step();
    check_value("burst_idle_credits", DW'(CREDITS), DW'(credits));
  endtask

  task automatic check_exit();
    check_value("exit_valid_before", 32'd0, DW'(exit_valid_o));
    write_word("exit_wr", AO_BASE + DW'(AO_EXIT_VALUE), EXIT_CODE);
    wait_idle();
    check_value("exit_valid", 32'd1, DW'(exit_valid_o));
    check_value("exit_value", EXIT_CODE, exit_value_o);
  endtask

  task automatic check_timer();
    write_word("tmr_clear", AO_BASE + DW'(AO_TIMER_CTRL), 32'h2);
    write_word("tmr_cmp", AO_BASE + DW'(AO_TIMER_CMP), TIMER_CMP);
    write_word("tmr_enable", AO_BASE + DW'(AO_TIMER_CTRL), 32'h1);
    wait_idle();
    wait_for("irq_timer_o", 1'b1);
    read_word("tmr_val", AO_BASE + DW'(AO_TIMER_VAL), '0, 1'b0);
    wait_idle();
    check_value("tmr_val_ge_cmp", 32'd1, DW'(last_rdata >= TIMER_CMP));
    // clear with enable dropped
    write_word("tmr_stop", AO_BASE + DW'(AO_TIMER_CTRL), 32'h2);
    wait_idle();
    check_value("tmr_irq_low", 32'd0, DW'(irq_timer_o));
    read_word("tmr_val_cleared", AO_BASE + DW'(AO_TIMER_VAL), '0, 1'b0);
    wait_idle();
    check_value("tmr_val_lt_cmp", 32'd1, DW'(last_rdata < TIMER_CMP));
  endtask

  task automatic check_sleep();
    write_word("slp_clear", AO_BASE + DW'(AO_TIMER_CTRL), 32'h2);
    write_word("slp_cmp", AO_BASE + DW'(AO_TIMER_CMP), TIMER_CMP);
    write_word("slp_req", AO_BASE + DW'(AO_SLEEP_REQ), 32'h1);
    wait_for("cpu_powergate_o", 1'b1);
    read_word("slp_state", AO_BASE + DW'(AO_PWR_STATE), DW'(PWR_SLEEP), 1'b1);
    wait_idle();
    // the timer interrupt wakes the cpu
    write_word("wake_enable", AO_BASE + DW'(AO_TIMER_CTRL), 32'h1);
    wait_for("cpu_powergate_o", 1'b0);
    read_word("wake_state", AO_BASE + DW'(AO_PWR_STATE), DW'(PWR_ACTIVE), 1'b1);
    write_word("wake_stop", AO_BASE + DW'(AO_TIMER_CTRL), 32'h2);
    wait_idle();
  endtask

  initial begin
    void'($urandom(32'h541f_c43c));
    credits      = CREDITS;
    value_errors = 0;
    other_errors = 0;
    last_rdata   = '0;
    rst_i        = 1'b1;
    req_valid_i  = 1'b0;
    req_op_i     = OP_READ;
    req_addr_i   = '0;
    req_wdata_i  = '0;
    repeat (10) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    check_value("irq_after_reset", 32'd0, DW'(irq_timer_o));
    check_value("powergate_after_reset", 32'd0, DW'(cpu_powergate_o));
    play_patterns();
    run_burst();
    check_exit();
    check_timer();
    check_sleep();
    end_run();
  end

endmodule

`default_nettype wire
